//--- snoop_handler.f
rtl/snoop_pkg.sv
rtl/snoop_wr_if.sv
rtl/snoop_ctrl.sv
rtl/snoop_meta_buf.sv
rtl/snoop_data_packer.sv
rtl/snoop_handler.sv
verification/snoop_handler_chk.sv
verification/tb_snoop_handler.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the snoop handler testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_snoop_handler \
    -f snoop_handler.f -o sim_snoop_handler \
    && ./obj_dir/sim_snoop_handler +verilator+error+limit+1000 | tee sim.log \
    || { echo "build or simulation aborted"; exit 1; }

grep -q "^PASS: all tests$" sim.log && ! grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- verification/tb_snoop_handler.sv
// Snoop handler testbench with random snoops, data array model and closing report
`timescale 1ns/1ps

module tb_snoop_handler
    import snoop_pkg::*;
();

    localparam int unsigned N_REQ       = 300;
    localparam longint     WATCHDOG_NS = longint'(N_REQ) * 40 * 40;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        req_valid_i, req_ready_o;
    snoop_op_t   req_op_i;
    set_t        req_set_i;
    tag_t        req_tag_i;
    way_t        req_way_i;
    logic        req_dir_valid_i, req_dir_wback_i, req_dir_dirty_i;
    logic        req_dir_shared_i, req_dir_fetch_i;
    logic        dir_updt_o, dir_updt_valid_o, dir_updt_wback_o;
    logic        dir_updt_dirty_o, dir_updt_shared_o, dir_updt_fetch_o;
    set_t        dir_updt_set_o;
    way_t        dir_updt_way_o;
    tag_t        dir_updt_tag_o;
    logic        data_read_o;
    set_t        data_read_set_o;
    way_t        data_read_way_o;
    word_idx_t   data_read_word_o;
    word_t       data_read_data_i;
    logic        snoop_rsp_meta_ready_i, snoop_rsp_meta_valid_o;
    snoop_meta_t snoop_rsp_meta_o;
    logic        snoop_rsp_data_ready_i, snoop_rsp_data_valid_o, snoop_rsp_last_o;
    beat_t       snoop_rsp_data_o;

    logic [31:0] seed = 32'h480f_66f5;
    int          errors = 0;
    int          n_req = 0;
    int          n_meta = 0;
    int          n_last = 0;
    // Lines that must come back, from the hit state of each accepted snoop
    int          n_line = 0;
    logic        rd_q = 1'b0;
    set_t        rd_set;
    way_t        rd_way;
    word_idx_t   rd_word;

    snoop_handler #(.FIFO_DEPTH(4)) dut (.*);

    bind snoop_handler snoop_handler_chk chk (.*);

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [1:0] way_index(way_t w);
        case (w)
            4'b0010: return 2'd1;
            4'b0100: return 2'd2;
            4'b1000: return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    // Array word: c5, 00, set, 0, way index, word index, 3c from the top bit down
    function automatic word_t array_word(set_t s, way_t w, word_idx_t i);
        return {8'hc5, 2'b00, s, 4'h0, way_index(w), i, 8'h3c};
    endfunction

    // Data array returns the word one cycle after the read strobe
    always @(negedge clk_i) begin
        rd_q    = data_read_o;
        rd_set  = data_read_set_o;
        rd_way  = data_read_way_o;
        rd_word = data_read_word_o;
    end

    always @(posedge clk_i) begin
        #2;
        data_read_data_i = rd_q ? array_word(rd_set, rd_way, rd_word) : 32'hdead_beef;
    end

    always @(negedge clk_i) begin
        if (rst_ni) begin
            n_req  += int'(req_valid_i && req_ready_o);
            n_meta += int'(snoop_rsp_meta_valid_o && snoop_rsp_meta_ready_i);
            n_last += int'(snoop_rsp_data_valid_o && snoop_rsp_data_ready_i &&
                           snoop_rsp_last_o);
        end
    end

    // One clock step with fresh random back-pressure
    task automatic cycle();
        logic [31:0] r;
        @(posedge clk_i);
        #2;
        r = lcg_next();
        snoop_rsp_meta_ready_i = r[3] | r[9];
        snoop_rsp_data_ready_i = r[5] | r[11];
    endtask

    task automatic send_request();
        logic [31:0] r;
        logic        took;
        r = lcg_next();
        req_op_i         = snoop_op_t'(8'd1 << r[2:0]);
        req_dir_valid_i  = r[6:4] != 3'd0;
        req_dir_wback_i  = r[7];
        req_set_i        = r[13:8];
        req_way_i        = way_t'(4'd1 << r[15:14]);
        req_dir_dirty_i  = r[16];
        req_dir_shared_i = r[17];
        req_dir_fetch_i  = r[18];
        req_tag_i        = r[31:12] ^ tag_t'(lcg_next() >> 12);
        req_valid_i      = 1'b1;
        do begin
            @(negedge clk_i);
            took = req_ready_o;
            cycle();
        end while (!took);
        // A hit returns data unless it is make_invalid or a clean op on a clean line
        if (req_dir_valid_i && !req_op_i.make_invalid &&
            (req_dir_dirty_i || !(req_op_i.clean_invalid || req_op_i.clean_shared))) begin
            n_line++;
        end
        req_valid_i = 1'b0;
        if (r[24]) begin
            cycle();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d accepted requests", n_req);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic drained;
        rst_ni                 = 1'b0;
        req_valid_i            = 1'b0;
        req_op_i               = '0;
        req_set_i              = '0;
        req_tag_i              = '0;
        req_way_i              = '0;
        req_dir_valid_i        = 1'b0;
        req_dir_wback_i        = 1'b0;
        req_dir_dirty_i        = 1'b0;
        req_dir_shared_i       = 1'b0;
        req_dir_fetch_i        = 1'b0;
        data_read_data_i       = '0;
        snoop_rsp_meta_ready_i = 1'b0;
        snoop_rsp_data_ready_i = 1'b0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        repeat (N_REQ) send_request();
        // Let the last snoop finish and all responses leave
        do begin
            @(negedge clk_i);
            drained = req_ready_o && !snoop_rsp_meta_valid_o && !snoop_rsp_data_valid_o;
            cycle();
        end while (!drained);
        repeat (4) cycle();
        if (n_meta != n_req) begin
            $display("ERR %0t metadata handshakes: got %0d expected %0d", $time, n_meta, n_req);
            errors++;
        end
        if (n_last != n_line) begin
            $display("ERR %0t snoop_rsp_last_o beats: got %0d expected %0d",
                     $time, n_last, n_line);
            errors++;
        end
        errors += int'(dut.chk.fails);
        $display("requests %0d, metadata %0d, last beats %0d, errors %0d",
                 n_req, n_meta, n_last, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verification/snoop_handler_chk.sv
// Snoop handler checker with assertions on metadata, beats, reads and directory updates
`timescale 1ns/1ps

module snoop_handler_chk
    import snoop_pkg::*;
(
    input logic        clk_i,
    input logic        rst_ni,
    input logic        req_valid_i,
    input logic        req_ready_o,
    input snoop_op_t   req_op_i,
    input set_t        req_set_i,
    input tag_t        req_tag_i,
    input way_t        req_way_i,
    input logic        req_dir_valid_i,
    input logic        req_dir_wback_i,
    input logic        req_dir_dirty_i,
    input logic        req_dir_shared_i,
    input logic        req_dir_fetch_i,
    input logic        dir_updt_o,
    input set_t        dir_updt_set_o,
    input way_t        dir_updt_way_o,
    input tag_t        dir_updt_tag_o,
    input logic        dir_updt_valid_o,
    input logic        dir_updt_wback_o,
    input logic        dir_updt_dirty_o,
    input logic        dir_updt_shared_o,
    input logic        dir_updt_fetch_o,
    input logic        data_read_o,
    input set_t        data_read_set_o,
    input way_t        data_read_way_o,
    input word_idx_t   data_read_word_o,
    input word_t       data_read_data_i,
    input logic        snoop_rsp_meta_ready_i,
    input logic        snoop_rsp_meta_valid_o,
    input snoop_meta_t snoop_rsp_meta_o,
    input logic        snoop_rsp_data_ready_i,
    input logic        snoop_rsp_data_valid_o,
    input beat_t       snoop_rsp_data_o,
    input logic        snoop_rsp_last_o
);

    int unsigned     fails = 0;
    snoop_meta_t     exp_meta;
    logic [4:0]      exp_dir;
    set_t            exp_set;
    tag_t            exp_tag;
    way_t            exp_way;
    logic            updt_due;
    int              rd_idx;
    logic            rd_pend;
    word_idx_t       rd_word_q;
    word_t           lo_word;
    // Expected beats with the last flag on top
    logic [BEAT_W:0] beat_mem [8];
    logic [2:0]      wp, rp;
    logic            accept, meta_hs, data_hs;

    assign accept  = req_valid_i && req_ready_o;
    assign meta_hs = snoop_rsp_meta_valid_o && snoop_rsp_meta_ready_i;
    assign data_hs = snoop_rsp_data_valid_o && snoop_rsp_data_ready_i;

    function automatic snoop_meta_t meta_rule(snoop_op_t op, logic hit, logic dirty, logic shr);
        snoop_meta_t m;
        m = '0;
        if (hit) begin
            m.was_unique = !shr;
            if (op.read_unique) begin
                m.pass_dirty    = dirty;
                m.data_transfer = 1'b1;
            end else if (op.clean_invalid) begin
                m.pass_dirty    = dirty;
                m.data_transfer = dirty;
            end else if (op.clean_shared) begin
                m.is_shared     = 1'b1;
                m.pass_dirty    = dirty;
                m.data_transfer = dirty;
            end else if (!op.make_invalid) begin
                // Shared reads and read_once keep the line here
                m.is_shared     = 1'b1;
                m.left_dirty    = dirty;
                m.data_transfer = 1'b1;
            end
        end
        return m;
    endfunction

    // Directory bits as {valid, wback, dirty, shared, fetch}
    function automatic logic [4:0] dir_rule(snoop_op_t op, logic wb, logic dirty,
                                            logic shr, logic fetch);
        if (op.read_clean || op.read_not_shared_dirty || op.read_shared) begin
            return {1'b1, wb, dirty, 1'b1, fetch};
        end else if (op.clean_shared) begin
            return {1'b1, wb, 1'b0, shr, fetch};
        end
        return 5'b0;
    endfunction

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            updt_due <= 1'b0;
            exp_meta <= '0;
            rd_idx   <= 0;
            rd_pend  <= 1'b0;
            wp       <= '0;
            rp       <= '0;
        end else begin
            if (accept) begin
                exp_meta <= meta_rule(req_op_i, req_dir_valid_i, req_dir_dirty_i,
                                      req_dir_shared_i);
                exp_dir  <= dir_rule(req_op_i, req_dir_wback_i, req_dir_dirty_i,
                                     req_dir_shared_i, req_dir_fetch_i);
                updt_due <= req_dir_valid_i && !req_op_i.read_once;
                exp_set  <= req_set_i;
                exp_tag  <= req_tag_i;
                exp_way  <= req_way_i;
                rd_idx   <= 0;
            end else if (data_read_o) begin
                rd_idx <= rd_idx + 1;
            end
            if (dir_updt_o) begin
                updt_due <= 1'b0;
            end
            rd_pend   <= data_read_o;
            rd_word_q <= data_read_word_o;
            if (rd_pend && !rd_word_q[0]) begin
                lo_word <= data_read_data_i;
            end else if (rd_pend) begin
                beat_mem[wp] <= {rd_word_q == 2'd3, data_read_data_i, lo_word};
                wp           <= wp + 3'd1;
            end
            if (data_hs) begin
                rp <= rp + 3'd1;
            end
        end
    end

    a_meta: assert property (@(posedge clk_i) disable iff (!rst_ni)
        meta_hs |-> snoop_rsp_meta_o == exp_meta)
        else begin
            $error("ERR %0t snoop_rsp_meta_o: got %h expected %h",
                   $time, $sampled(snoop_rsp_meta_o), $sampled(exp_meta));
            fails++;
        end

    a_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_hs |-> wp != rp && {snoop_rsp_last_o, snoop_rsp_data_o} == beat_mem[rp])
        else begin
            $error("ERR %0t snoop_rsp_data_o: got %h expected %h", $time,
                   $sampled({snoop_rsp_last_o, snoop_rsp_data_o}), $sampled(beat_mem[rp]));
            fails++;
        end

    a_meta_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        snoop_rsp_meta_valid_o && !snoop_rsp_meta_ready_i |=>
        snoop_rsp_meta_valid_o && $stable(snoop_rsp_meta_o))
        else begin
            $error("metadata response changed or dropped while stalled");
            fails++;
        end

    a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        snoop_rsp_data_valid_o && !snoop_rsp_data_ready_i |=>
        snoop_rsp_data_valid_o && $stable({snoop_rsp_last_o, snoop_rsp_data_o}))
        else begin
            $error("data beat changed or dropped while stalled");
            fails++;
        end

    a_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_read_o |-> exp_meta.data_transfer && rd_idx < 4 &&
        int'(data_read_word_o) == rd_idx &&
        data_read_set_o == exp_set && data_read_way_o == exp_way)
        else begin
            $error("data array read outside the expected line sequence");
            fails++;
        end

    a_dir: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dir_updt_o |-> updt_due && dir_updt_set_o == exp_set &&
        dir_updt_way_o == exp_way && dir_updt_tag_o == exp_tag &&
        {dir_updt_valid_o, dir_updt_wback_o, dir_updt_dirty_o, dir_updt_shared_o,
         dir_updt_fetch_o} == exp_dir)
        else begin
            $error("unexpected or wrong directory update");
            fails++;
        end

    a_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept |-> !updt_due && (!exp_meta.data_transfer || rd_idx == 4))
        else begin
            $error("request accepted before the previous one finished");
            fails++;
        end

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept || snoop_rsp_meta_valid_o |=> !req_ready_o || !snoop_rsp_meta_valid_o)
        else begin
            $error("request ready while metadata is still waiting");
            fails++;
        end

    a_ready_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept |=> !req_ready_o)
        else begin
            $error("request ready stayed high right after acceptance");
            fails++;
        end

endmodule

//--- rtl/snoop_handler.sv
// Snoop handler top joining the controller, metadata buffer and beat packer
`timescale 1ns/1ps

module snoop_handler
    import snoop_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,

    // Snoop request with directory state of the line
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  snoop_op_t   req_op_i,
    input  set_t        req_set_i,
    input  tag_t        req_tag_i,
    input  way_t        req_way_i,
    input  logic        req_dir_valid_i,
    input  logic        req_dir_wback_i,
    input  logic        req_dir_dirty_i,
    input  logic        req_dir_shared_i,
    input  logic        req_dir_fetch_i,

    // Directory update
    output logic        dir_updt_o,
    output set_t        dir_updt_set_o,
    output way_t        dir_updt_way_o,
    output tag_t        dir_updt_tag_o,
    output logic        dir_updt_valid_o,
    output logic        dir_updt_wback_o,
    output logic        dir_updt_dirty_o,
    output logic        dir_updt_shared_o,
    output logic        dir_updt_fetch_o,

    // Data array read, word returns one cycle later
    output logic        data_read_o,
    output set_t        data_read_set_o,
    output way_t        data_read_way_o,
    output word_idx_t   data_read_word_o,
    input  word_t       data_read_data_i,

    // Snoop responses
    input  logic        snoop_rsp_meta_ready_i,
    output logic        snoop_rsp_meta_valid_o,
    output snoop_meta_t snoop_rsp_meta_o,
    input  logic        snoop_rsp_data_ready_i,
    output logic        snoop_rsp_data_valid_o,
    output beat_t       snoop_rsp_data_o,
    output logic        snoop_rsp_last_o
);

    logic        ctrl_idle;
    logic        meta_w;
    logic        meta_wok;
    snoop_meta_t meta_wdata;

    snoop_wr_if wr_if ();

    // New snoop only when nothing is left over from the last one
    assign req_ready_o = ctrl_idle && meta_wok && wr_if.wok;

    snoop_ctrl u_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .req_valid_i       (req_valid_i),
        .req_op_i          (req_op_i),
        .req_set_i         (req_set_i),
        .req_tag_i         (req_tag_i),
        .req_way_i         (req_way_i),
        .req_dir_valid_i   (req_dir_valid_i),
        .req_dir_wback_i   (req_dir_wback_i),
        .req_dir_dirty_i   (req_dir_dirty_i),
        .req_dir_shared_i  (req_dir_shared_i),
        .req_dir_fetch_i   (req_dir_fetch_i),
        .req_accept_i      (req_ready_o),
        .req_idle_o        (ctrl_idle),
        .meta_w_o          (meta_w),
        .meta_wok_i        (meta_wok),
        .meta_wdata_o      (meta_wdata),
        .data_read_o       (data_read_o),
        .data_read_set_o   (data_read_set_o),
        .data_read_way_o   (data_read_way_o),
        .data_read_word_o  (data_read_word_o),
        .data_read_data_i  (data_read_data_i),
        .dir_updt_o        (dir_updt_o),
        .dir_updt_set_o    (dir_updt_set_o),
        .dir_updt_way_o    (dir_updt_way_o),
        .dir_updt_tag_o    (dir_updt_tag_o),
        .dir_updt_valid_o  (dir_updt_valid_o),
        .dir_updt_wback_o  (dir_updt_wback_o),
        .dir_updt_dirty_o  (dir_updt_dirty_o),
        .dir_updt_shared_o (dir_updt_shared_o),
        .dir_updt_fetch_o  (dir_updt_fetch_o),
        .wr                (wr_if.ctrl)
    );

    snoop_meta_buf u_meta_buf (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (meta_w),
        .wok_o   (meta_wok),
        .wdata_i (meta_wdata),
        .r_i     (snoop_rsp_meta_ready_i),
        .rok_o   (snoop_rsp_meta_valid_o),
        .rdata_o (snoop_rsp_meta_o)
    );

    snoop_data_packer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_packer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .wr      (wr_if.pack),
        .r_i     (snoop_rsp_data_ready_i),
        .rok_o   (snoop_rsp_data_valid_o),
        .rdata_o (snoop_rsp_data_o),
        .rlast_o (snoop_rsp_last_o)
    );

endmodule

//--- rtl/snoop_data_packer.sv
// Packs access words into memory beats, queues them and flags the last beat of a line
`timescale 1ns/1ps

module snoop_data_packer
    import snoop_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    snoop_wr_if.pack wr,
    input  logic     r_i,
    output logic     rok_o,
    output beat_t    rdata_o,
    output logic     rlast_o
);

    localparam int unsigned PTR_W  = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int unsigned BCNT_W = $clog2(BEATS_PER_LINE);

    word_t             lo_q;
    logic              half_q;
    beat_t             mem_q [FIFO_DEPTH];
    beat_t             beat;
    logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [BCNT_W-1:0] beat_cnt_q;
    logic              word_take;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    // Room for one whole beat; a started beat always has its slot
    assign wr.wok    = cnt_q < CNT_W'(FIFO_DEPTH);
    assign word_take = wr.w && wr.wok;

    // A beat closes on its second word, or early when the line ends
    assign push = word_take && (half_q || wr.wlast);
    assign beat = half_q ? {wr.wdata, lo_q} : {{WORD_W{1'b0}}, wr.wdata};

    assign rok_o   = (cnt_q != '0);
    assign rdata_o = mem_q[rd_ptr_q];
    assign pop     = rok_o && r_i;
    assign rlast_o = (beat_cnt_q == BCNT_W'(BEATS_PER_LINE - 1));

    // Word 0 waits in the low half
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            half_q <= 1'b0;
        end else if (word_take) begin
            half_q <= !push;
        end
    end

    always_ff @(posedge clk_i) begin
        if (word_take && !push) begin
            lo_q <= wr.wdata;
        end
        if (push) begin
            mem_q[wr_ptr_q] <= beat;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + CNT_W'(1);
                2'b01:   cnt_q <= cnt_q - CNT_W'(1);
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // Position of the head beat within its line
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_cnt_q <= '0;
        end else if (pop) begin
            if (rlast_o) begin
                beat_cnt_q <= '0;
            end else begin
                beat_cnt_q <= beat_cnt_q + BCNT_W'(1);
            end
        end
    end

endmodule

//--- rtl/snoop_meta_buf.sv
// One-entry registered buffer holding a snoop metadata response until taken
`timescale 1ns/1ps

module snoop_meta_buf
    import snoop_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        w_i,
    output logic        wok_o,
    input  snoop_meta_t wdata_i,
    input  logic        r_i,
    output logic        rok_o,
    output snoop_meta_t rdata_o
);

    logic        full_q;
    snoop_meta_t data_q;

    // Output comes from the register only, never straight from wdata_i
    assign wok_o   = !full_q;
    assign rok_o   = full_q;
    assign rdata_o = data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (w_i && wok_o) begin
            full_q <= 1'b1;
        end else if (r_i && rok_o) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_i && wok_o) begin
            data_q <= wdata_i;
        end
    end

endmodule

//--- rtl/snoop_ctrl.sv
// Snoop controller FSM with request capture, metadata, line reads and directory update
`timescale 1ns/1ps

module snoop_ctrl
    import snoop_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        req_valid_i,
    input  snoop_op_t   req_op_i,
    input  set_t        req_set_i,
    input  tag_t        req_tag_i,
    input  way_t        req_way_i,
    input  logic        req_dir_valid_i,
    input  logic        req_dir_wback_i,
    input  logic        req_dir_dirty_i,
    input  logic        req_dir_shared_i,
    input  logic        req_dir_fetch_i,
    input  logic        req_accept_i,
    output logic        req_idle_o,
    output logic        meta_w_o,
    input  logic        meta_wok_i,
    output snoop_meta_t meta_wdata_o,
    output logic        data_read_o,
    output set_t        data_read_set_o,
    output way_t        data_read_way_o,
    output word_idx_t   data_read_word_o,
    input  word_t       data_read_data_i,
    output logic        dir_updt_o,
    output set_t        dir_updt_set_o,
    output way_t        dir_updt_way_o,
    output tag_t        dir_updt_tag_o,
    output logic        dir_updt_valid_o,
    output logic        dir_updt_wback_o,
    output logic        dir_updt_dirty_o,
    output logic        dir_updt_shared_o,
    output logic        dir_updt_fetch_o,
    snoop_wr_if.ctrl    wr
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD_FIRST,
        S_RD_NEXT,
        S_DIR_UPDT
    } state_e;

    state_e      state_q, state_d;
    word_idx_t   rd_word_q, rd_word_d;
    logic        active_q;
    logic        start;
    logic        no_data_updt;
    logic        eol;
    snoop_op_t   op_q;
    set_t        set_q;
    tag_t        tag_q;
    way_t        way_q;
    logic        wback_q, dirty_q, shared_q, fetch_q;

    // Ready is only offered once the first edge after reset has passed
    assign req_idle_o = (state_q == S_IDLE) && active_q;
    assign start      = req_valid_i && req_accept_i;
    assign meta_w_o   = start && meta_wok_i;

    // Clean and invalidate ops still update the entry when no data moves
    assign no_data_updt = req_dir_valid_i &&
        (req_op_i.clean_invalid || req_op_i.clean_shared || req_op_i.make_invalid);

    // Read index has wrapped once the last word of the line was read
    assign eol = (rd_word_q == '0);

    always_comb begin
        meta_wdata_o = '0;
        if (req_dir_valid_i) begin
            meta_wdata_o.was_unique = !req_dir_shared_i;
            unique case (1'b1)
                req_op_i.read_clean,
                req_op_i.read_not_shared_dirty,
                req_op_i.read_once,
                req_op_i.read_shared: begin
                    // Line stays here and keeps its dirty state
                    meta_wdata_o.is_shared     = 1'b1;
                    meta_wdata_o.left_dirty    = req_dir_dirty_i;
                    meta_wdata_o.data_transfer = 1'b1;
                end
                req_op_i.read_unique: begin
                    meta_wdata_o.pass_dirty    = req_dir_dirty_i;
                    meta_wdata_o.data_transfer = 1'b1;
                end
                req_op_i.clean_invalid: begin
                    meta_wdata_o.pass_dirty    = req_dir_dirty_i;
                    meta_wdata_o.data_transfer = req_dir_dirty_i;
                end
                req_op_i.clean_shared: begin
                    meta_wdata_o.is_shared     = 1'b1;
                    meta_wdata_o.pass_dirty    = req_dir_dirty_i;
                    meta_wdata_o.data_transfer = req_dir_dirty_i;
                end
                req_op_i.make_invalid: begin
                    // Entry is dropped without any data
                end
                default: begin
                    meta_wdata_o = '0;
                end
            endcase
        end
    end

    always_comb begin
        state_d           = state_q;
        rd_word_d         = rd_word_q;
        data_read_o       = 1'b0;
        wr.w              = 1'b0;
        wr.wlast          = 1'b0;
        dir_updt_o        = 1'b0;
        dir_updt_valid_o  = 1'b0;
        dir_updt_wback_o  = 1'b0;
        dir_updt_dirty_o  = 1'b0;
        dir_updt_shared_o = 1'b0;
        dir_updt_fetch_o  = 1'b0;

        case (state_q)
            S_IDLE: begin
                if (start) begin
                    if (meta_wdata_o.data_transfer) begin
                        state_d = S_RD_FIRST;
                    end else if (no_data_updt) begin
                        state_d = S_DIR_UPDT;
                    end
                end
            end
            S_RD_FIRST: begin
                if (wr.wok) begin
                    data_read_o = 1'b1;
                    rd_word_d   = rd_word_q + word_idx_t'(1);
                    state_d     = S_RD_NEXT;
                end
            end
            S_RD_NEXT: begin
                // Word read on the previous cycle goes to the packer now
                wr.w     = 1'b1;
                wr.wlast = eol;
                if (eol) begin
                    state_d = op_q.read_once ? S_IDLE : S_DIR_UPDT;
                end else if (rd_word_q[0] && wr.wok) begin
                    // Odd word completes the beat just started
                    data_read_o = 1'b1;
                    rd_word_d   = rd_word_q + word_idx_t'(1);
                end else begin
                    state_d = S_RD_FIRST;
                end
            end
            S_DIR_UPDT: begin
                dir_updt_o = 1'b1;
                state_d    = S_IDLE;
                if (op_q.read_clean || op_q.read_not_shared_dirty || op_q.read_shared) begin
                    dir_updt_valid_o  = 1'b1;
                    dir_updt_wback_o  = wback_q;
                    dir_updt_dirty_o  = dirty_q;
                    dir_updt_shared_o = 1'b1;
                    dir_updt_fetch_o  = fetch_q;
                end else if (op_q.clean_shared) begin
                    dir_updt_valid_o  = 1'b1;
                    dir_updt_wback_o  = wback_q;
                    dir_updt_shared_o = shared_q;
                    dir_updt_fetch_o  = fetch_q;
                end
                // read_unique, clean_invalid and make_invalid leave an invalid entry
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= S_IDLE;
            rd_word_q <= '0;
            active_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_word_q <= rd_word_d;
            active_q  <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            op_q     <= req_op_i;
            set_q    <= req_set_i;
            tag_q    <= req_tag_i;
            way_q    <= req_way_i;
            wback_q  <= req_dir_wback_i;
            dirty_q  <= req_dir_dirty_i;
            shared_q <= req_dir_shared_i;
            fetch_q  <= req_dir_fetch_i;
        end
    end

    assign wr.wdata         = data_read_data_i;
    assign data_read_set_o  = set_q;
    assign data_read_way_o  = way_q;
    assign data_read_word_o = rd_word_q;
    assign dir_updt_set_o   = set_q;
    assign dir_updt_way_o   = way_q;
    assign dir_updt_tag_o   = tag_q;

endmodule

//--- rtl/snoop_wr_if.sv
// Word write channel from the snoop controller into the beat packer
`timescale 1ns/1ps

interface snoop_wr_if
    import snoop_pkg::*;
();

    logic  w;
    logic  wok;
    word_t wdata;
    // Marks the final word of a line
    logic  wlast;

    modport ctrl (
        output w,
        output wdata,
        output wlast,
        input  wok
    );

    modport pack (
        input  w,
        input  wdata,
        input  wlast,
        output wok
    );

endinterface

//--- rtl/snoop_pkg.sv
// Snoop handler package with line geometry, cache field types and snoop encodings
package snoop_pkg;

    // Line and beat geometry
    localparam int unsigned CL_WORDS       = 4;
    localparam int unsigned WORDS_PER_BEAT = 2;
    localparam int unsigned BEATS_PER_LINE = CL_WORDS / WORDS_PER_BEAT;
    localparam int unsigned WORD_W         = 32;
    localparam int unsigned BEAT_W         = WORD_W * WORDS_PER_BEAT;

    // Directory geometry
    localparam int unsigned SET_W = 6;
    localparam int unsigned TAG_W = 20;
    localparam int unsigned WAYS  = 4;

    typedef logic [SET_W-1:0]            set_t;
    typedef logic [TAG_W-1:0]            tag_t;
    // One bit per way, exactly one set on a hit
    typedef logic [WAYS-1:0]             way_t;
    typedef logic [$clog2(CL_WORDS)-1:0] word_idx_t;
    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [BEAT_W-1:0]           beat_t;

    // Snoop operation, one-hot
    typedef struct packed {
        logic read_clean;
        logic read_not_shared_dirty;
        logic read_once;
        logic read_shared;
        logic read_unique;
        logic clean_invalid;
        logic clean_shared;
        logic make_invalid;
    } snoop_op_t;

    // Metadata returned for every snoop
    typedef struct packed {
        logic was_unique;
        logic is_shared;
        logic pass_dirty;
        logic left_dirty;
        logic data_transfer;
    } snoop_meta_t;

endpackage
